// File: source/bridge_pkg.sv
package bridge_pkg;

  localparam int microstep_bits = 5;  // 32 microsteps per electrical cycle
  localparam int vref_width = 8;

  // Microsteps in one quarter of the electrical cycle
  localparam int quarter_steps = 2 ** (microstep_bits - 2);

  // Cosine over one quarter, entry 0 is full current
  localparam logic [vref_width-1:0] quarter_table [quarter_steps] = '{
    8'd255,
    8'd250,
    8'd236,
    8'd212,
    8'd180,
    8'd142,
    8'd98,
    8'd50
  };

  // Low-side bridge drive and current references for both phases
  typedef struct packed {
    logic                  phase_a1;
    logic                  phase_a2;
    logic                  phase_b1;
    logic                  phase_b2;
    logic [vref_width-1:0] vref_a;
    logic [vref_width-1:0] vref_b;
  } phase_drive_t;

endpackage

// File: source/motion_pkg.sv
package motion_pkg;

  localparam int step_count_width = 16;
  localparam int period_width = 16;   // Clock cycles per step
  localparam int min_period = 4;      // Shorter periods are stretched to this
  localparam int tag_width = 8;
  localparam int enc_width = 32;

  localparam int move_fifo_depth = 8;
  localparam int status_fifo_depth = 4;

  // One move as queued by the command decoder
  typedef struct packed {
    logic [tag_width-1:0]        tag;
    logic                        dir;     // 1 is forward
    logic [step_count_width-1:0] steps;
    logic [period_width-1:0]     period;
  } move_cmd_t;

  // Completion record of a move
  typedef struct packed {
    logic [tag_width-1:0]                  tag;
    logic [bridge_pkg::microstep_bits-1:0] microstep;
    logic signed [enc_width-1:0]           enc_count;
    logic                                  enc_fault;
  } move_status_t;

endpackage

// File: source/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic     CLK,
  input  logic     resetn,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;

  payload_t mem [depth];

  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [ptr_bits:0]   count;   // Occupancy from 0 to depth
  logic                push;
  logic                pop;

  assign in_ready  = (count != (ptr_bits + 1)'(depth));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];   // Head of queue falls through

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // Explicit wrap so any depth works
        wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Both or neither
      endcase
    end
  end

  // Pointers meet only when empty or full, so no push overwrites a held item
  a_no_overflow: assert property (@(posedge CLK) disable iff (!resetn)
    (wr_ptr == rd_ptr) == (!out_valid || !in_ready));

  // Stalled head item is held until taken
  a_out_stable: assert property (@(posedge CLK) disable iff (!resetn)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: source/step_timer.sv
`timescale 1ns/1ps

module step_timer (
  input  logic                                   CLK,
  input  logic                                   resetn,
  input  logic                                   cmd_valid,
  output logic                                   cmd_ready,
  input  motion_pkg::move_cmd_t                  cmd,
  output logic                                   step_pulse,
  output logic                                   step_dir,
  input  logic [bridge_pkg::microstep_bits-1:0]  microstep,
  input  logic signed [motion_pkg::enc_width-1:0] enc_count,
  input  logic                                   enc_fault,
  output logic                                   status_valid,
  input  logic                                   status_ready,
  output motion_pkg::move_status_t               status
);

  import motion_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_step,
    st_report
  } state_t;

  state_t                      state;
  logic [period_width-1:0]     period_reg;   // Effective period of the move
  logic [period_width-1:0]     period_cnt;
  logic [step_count_width-1:0] steps_left;
  logic [tag_width-1:0]        tag_reg;
  logic [period_width-1:0]     cmd_period;
  logic                        accept;
  logic                        finished;
  logic                        load_status;

  assign cmd_ready = (state == st_idle);
  assign accept    = cmd_valid && cmd_ready;

  // Raise short periods to the minimum
  assign cmd_period = (cmd.period < period_width'(min_period)) ?
                      period_width'(min_period) : cmd.period;

  assign finished     = (steps_left == '0);
  assign step_pulse   = (state == st_step) && !finished && (period_cnt == period_reg);
  assign status_valid = (state == st_report);

  // Zero-step moves report straight away, others once the last step is in
  assign load_status = (accept && (cmd.steps == '0)) || ((state == st_step) && finished);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state      <= st_idle;
      period_cnt <= '0;
      steps_left <= '0;
      step_dir   <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            step_dir   <= cmd.dir;
            period_cnt <= period_width'(1);
            steps_left <= cmd.steps;
            state      <= (cmd.steps == '0) ? st_report : st_step;
          end
        end
        st_step: begin
          if (finished) begin
            state <= st_report;   // Sequencer index already holds the last step
          end else if (step_pulse) begin
            period_cnt <= period_width'(1);
            steps_left <= steps_left - 1'b1;
          end else begin
            period_cnt <= period_cnt + 1'b1;
          end
        end
        st_report: begin
          if (status_ready) begin
            state <= st_idle;   // Stays here while the status FIFO is full
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Move payload and the status snapshot
  always_ff @(posedge CLK) begin
    if (accept) begin
      tag_reg    <= cmd.tag;
      period_reg <= cmd_period;
    end
    if (load_status) begin
      status.tag       <= accept ? cmd.tag : tag_reg;
      status.microstep <= microstep;
      status.enc_count <= enc_count;
      status.enc_fault <= enc_fault;
    end
  end

  // Pulses only while stepping, and never two in a row
  a_pulse_in_step: assert property (@(posedge CLK) disable iff (!resetn)
    step_pulse |-> (state == st_step) ##1 !step_pulse);

  a_status_hold: assert property (@(posedge CLK) disable iff (!resetn)
    status_valid && !status_ready |=> status_valid && $stable(status));

endmodule

// File: source/phase_sequencer.sv
`timescale 1ns/1ps

module phase_sequencer (
  input  logic                                  CLK,
  input  logic                                  resetn,
  input  logic                                  enable,
  input  logic                                  step_pulse,
  input  logic                                  step_dir,
  output logic [bridge_pkg::microstep_bits-1:0] microstep,
  output bridge_pkg::phase_drive_t              drive
);

  import bridge_pkg::*;

  logic [microstep_bits-1:0] index_next;
  logic [microstep_bits-1:0] index_b;     // Phase B lags A by a quarter
  phase_drive_t              drive_next;

  // Current magnitude of a phase at the given index
  function automatic logic [vref_width-1:0] phase_level(
    input logic [microstep_bits-1:0] idx
  );
    logic [1:0]                quad;
    logic [microstep_bits-3:0] k;
    logic [microstep_bits-3:0] mirror;
    quad   = idx[microstep_bits-1 -: 2];
    k      = idx[microstep_bits-3:0];
    mirror = -k;   // Same as quarter_steps - k for nonzero k
    if (!quad[0]) begin
      phase_level = quarter_table[k];
    end else if (k == '0) begin
      phase_level = '0;   // Zero crossing
    end else begin
      phase_level = quarter_table[mirror];
    end
  endfunction

  // Positive current in quadrants 0 and 3
  function automatic logic phase_positive(input logic [microstep_bits-1:0] idx);
    phase_positive = (idx[microstep_bits-1] == idx[microstep_bits-2]);
  endfunction

  always_comb begin
    index_next = microstep;
    if (step_pulse) begin
      index_next = step_dir ? microstep + 1'b1 : microstep - 1'b1;
    end
    index_b = index_next - microstep_bits'(quarter_steps);

    drive_next = '0;   // Bridge off when disabled
    if (enable) begin
      drive_next.phase_a1 = phase_positive(index_next);
      drive_next.phase_a2 = !phase_positive(index_next);
      drive_next.phase_b1 = phase_positive(index_b);
      drive_next.phase_b2 = !phase_positive(index_b);
      drive_next.vref_a   = phase_level(index_next);
      drive_next.vref_b   = phase_level(index_b);
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      microstep <= '0;
      drive     <= '0;
    end else begin
      microstep <= index_next;   // Keeps counting with the bridge off
      drive     <= drive_next;
    end
  end

  // No shoot-through on either bridge
  a_no_cross: assert property (@(posedge CLK) disable iff (!resetn)
    !(drive.phase_a1 && drive.phase_a2) && !(drive.phase_b1 && drive.phase_b2));

endmodule

// File: source/quad_decoder.sv
`timescale 1ns/1ps

module quad_decoder (
  input  logic                                    CLK,
  input  logic                                    resetn,
  input  logic                                    enc_a,
  input  logic                                    enc_b,
  output logic signed [motion_pkg::enc_width-1:0] count,
  output logic                                    fault
);

  import motion_pkg::*;

  logic [1:0] sync_a;     // Two-flop synchronizers with bit 1 as the safe one
  logic [1:0] sync_b;
  logic [1:0] cur_pos;
  logic [1:0] prev_pos;
  logic [1:0] delta;

  // Gray 00, 01, 11, 10 to position 0..3
  assign cur_pos = {sync_a[1], sync_a[1] ^ sync_b[1]};
  assign delta   = cur_pos - prev_pos;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sync_a   <= '0;
      sync_b   <= '0;
      prev_pos <= '0;
      count    <= '0;
      fault    <= 1'b0;
    end else begin
      sync_a   <= {sync_a[0], enc_a};
      sync_b   <= {sync_b[0], enc_b};
      prev_pos <= cur_pos;
      case (delta)
        2'd1: count <= count + enc_width'(1);   // Forward
        2'd3: count <= count - enc_width'(1);   // Backward
        2'd2: fault <= 1'b1;                    // Both bits moved so position is lost
        default: ;
      endcase
    end
  end

endmodule

// File: source/motion_top.sv
`timescale 1ns/1ps

module motion_top (
  input  logic                     CLK,
  input  logic                     resetn,
  input  logic                     enable,
  input  logic                     move_valid,
  output logic                     move_ready,
  input  motion_pkg::move_cmd_t    move,
  input  logic                     enc_a,
  input  logic                     enc_b,
  output bridge_pkg::phase_drive_t drive,
  output logic                     status_valid,
  input  logic                     status_ready,
  output motion_pkg::move_status_t status
);

  import motion_pkg::*;
  import bridge_pkg::*;

  // Move FIFO to step timer
  logic      cmd_valid;
  logic      cmd_ready;
  move_cmd_t cmd;

  // Step timer to status FIFO
  logic         rec_valid;
  logic         rec_ready;
  move_status_t rec;

  logic                        step_pulse;
  logic                        step_dir;
  logic [microstep_bits-1:0]   microstep;
  logic signed [enc_width-1:0] enc_count;
  logic                        enc_fault;

  stream_fifo #(
    .payload_t (move_cmd_t),
    .depth     (move_fifo_depth)
  ) u_move_fifo (
    .CLK       (CLK),
    .resetn    (resetn),
    .in_valid  (move_valid),
    .in_ready  (move_ready),
    .in_data   (move),
    .out_valid (cmd_valid),
    .out_ready (cmd_ready),
    .out_data  (cmd)
  );

  step_timer u_step_timer (
    .CLK          (CLK),
    .resetn       (resetn),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd          (cmd),
    .step_pulse   (step_pulse),
    .step_dir     (step_dir),
    .microstep    (microstep),
    .enc_count    (enc_count),
    .enc_fault    (enc_fault),
    .status_valid (rec_valid),
    .status_ready (rec_ready),
    .status       (rec)
  );

  phase_sequencer u_phase_seq (
    .CLK        (CLK),
    .resetn     (resetn),
    .enable     (enable),
    .step_pulse (step_pulse),
    .step_dir   (step_dir),
    .microstep  (microstep),
    .drive      (drive)
  );

  quad_decoder u_quad_dec (
    .CLK    (CLK),
    .resetn (resetn),
    .enc_a  (enc_a),
    .enc_b  (enc_b),
    .count  (enc_count),
    .fault  (enc_fault)
  );

  stream_fifo #(
    .payload_t (move_status_t),
    .depth     (status_fifo_depth)
  ) u_status_fifo (
    .CLK       (CLK),
    .resetn    (resetn),
    .in_valid  (rec_valid),
    .in_ready  (rec_ready),
    .in_data   (rec),
    .out_valid (status_valid),
    .out_ready (status_ready),
    .out_data  (status)
  );

endmodule

// File: tests/tb_motion_top.sv
`timescale 1ns/1ps

module tb_motion_top;

  import motion_pkg::*;
  import bridge_pkg::*;

  // Quarter-wave levels with the zero crossing as entry 8
  localparam int level_table [9] = '{255, 250, 236, 212, 180, 142, 98, 50, 0};
  localparam int capacity = move_fifo_depth + status_fifo_depth + 1;   // Moves held in a full stall
  // Steps times period of every test plus margin for overhead and encoder walks
  localparam int watchdog_cycles = 40 * 20 * 12 + 9 * 20 * 12 + 20 * 3 * min_period +
                                   20 * 12 + 20000;

  logic         CLK;
  logic         resetn;
  logic         enable;
  logic         move_valid;
  logic         move_ready;
  move_cmd_t    move;
  logic         enc_a;
  logic         enc_b;
  phase_drive_t drive;
  logic         status_valid;
  logic         status_ready;
  move_status_t status;

  logic [31:0]                 rng = 32'h880f;
  move_status_t                expected [$];   // Records still to come out in order
  logic [tag_width-1:0]        next_tag = '0;
  int                          model_index = 0;
  logic signed [enc_width-1:0] model_count = '0;
  logic                        model_fault = 1'b0;
  int                          enc_pos = 0;    // Encoder position 0..3 in Gray order
  int                          errors = 0;
  int                          test_errors = 0;
  int                          tests_passed = 0;
  int                          tests_failed = 0;
  int                          accepted = 0;
  logic                        full_seen = 1'b0;

  motion_top i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() % n);
  endfunction

  // Magnitude of one phase at a microstep index
  function automatic int model_level(input int idx);
    int q;
    int k;
    q = (idx >> 3) & 3;
    k = idx & 7;
    if (q == 0 || q == 2) begin
      return level_table[k];
    end
    return level_table[8 - k];   // Falling half of the quadrant
  endfunction

  function automatic phase_drive_t model_drive(input int idx, input logic en);
    phase_drive_t d;
    int           idx_b;
    logic         pos_a;
    logic         pos_b;
    d = '0;
    idx_b = (idx - 8) & 31;
    pos_a = (((idx >> 3) & 3) == 0) || (((idx >> 3) & 3) == 3);
    pos_b = (((idx_b >> 3) & 3) == 0) || (((idx_b >> 3) & 3) == 3);
    if (en) begin
      d.phase_a1 = pos_a;
      d.phase_a2 = !pos_a;
      d.phase_b1 = pos_b;
      d.phase_b2 = !pos_b;
      d.vref_a   = vref_width'(model_level(idx));
      d.vref_b   = vref_width'(model_level(idx_b));
    end
    return d;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    errors++;
  endtask

  // Queues the expected record and holds the move on the stream until taken
  task automatic issue_move(input int steps, input int period, input logic dir);
    move_status_t e;
    logic         taken;
    model_index = (model_index + (dir ? steps : -steps)) & 31;
    e.tag       = next_tag;
    e.microstep = microstep_bits'(model_index);
    e.enc_count = model_count;
    e.enc_fault = model_fault;
    expected.push_back(e);
    move.tag    = next_tag;
    move.dir    = dir;
    move.steps  = step_count_width'(steps);
    move.period = period_width'(period);
    next_tag++;
    move_valid = 1'b1;
    do begin
      @(negedge CLK);
      taken = move_ready;
      if (!taken) full_seen = 1'b1;
      @(posedge CLK);
      #1;
    end while (!taken);
    move_valid = 1'b0;
    accepted++;
  endtask

  task automatic wait_drain();
    while (expected.size() != 0) @(posedge CLK);
    repeat (2) @(posedge CLK);   // Last pop and timer back to idle
    #1;
  endtask

  task automatic check_drive();
    phase_drive_t e;
    @(negedge CLK);
    e = model_drive(model_index, enable);
    if (drive !== e) report_mismatch("drive", e, drive);
    @(posedge CLK);
    #1;
  endtask

  // One encoder move where delta 2 flips both lines at once
  task automatic enc_move(input int delta);
    enc_pos = (enc_pos + delta) & 3;
    enc_a   = enc_pos[1];
    enc_b   = enc_pos[1] ^ enc_pos[0];
    if (delta == 2) model_fault = 1'b1;
    else model_count = model_count + delta;
    repeat (4 + rand_below(3)) @(posedge CLK);
    #1;
  endtask

  task automatic end_test(input string name);
    if (errors == test_errors) begin
      $display("%s: ok", name);
      tests_passed++;
    end else begin
      $display("%s: %0d error(s)", name, errors - test_errors);
      tests_failed++;
    end
    test_errors = errors;
  endtask

  // Compares every status record that leaves the DUT
  initial begin
    move_status_t e;
    forever begin
      @(negedge CLK);
      if (resetn && status_valid && status_ready) begin
        if (expected.size() == 0) begin
          $display("Status record with tag %h came out with no move outstanding", status.tag);
          errors++;
        end else begin
          e = expected.pop_front();
          if (status.tag !== e.tag) report_mismatch("status.tag", e.tag, status.tag);
          if (status.microstep !== e.microstep)
            report_mismatch("status.microstep", e.microstep, status.microstep);
          if (status.enc_count !== e.enc_count)
            report_mismatch("status.enc_count", e.enc_count, status.enc_count);
          if (status.enc_fault !== e.enc_fault)
            report_mismatch("status.enc_fault", e.enc_fault, status.enc_fault);
        end
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge CLK);
    $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("test failed");
    $finish;
  end

  initial begin
    resetn       = 1'b0;
    enable       = 1'b0;
    move_valid   = 1'b0;
    move         = '0;
    enc_a        = 1'b0;
    enc_b        = 1'b0;
    status_ready = 1'b1;

    // Drive held off in reset with either enable
    repeat (4) @(posedge CLK);
    #1;
    if (drive !== '0) report_mismatch("drive", 0, drive);
    enable = 1'b1;
    repeat (4) @(posedge CLK);
    #1;
    if (drive !== '0) report_mismatch("drive", 0, drive);
    enable = 1'b0;
    resetn = 1'b1;
    @(negedge CLK);
    if (move_ready !== 1'b1) report_mismatch("move_ready", 1, move_ready);
    if (status_valid !== 1'b0) report_mismatch("status_valid", 0, status_valid);
    check_drive();
    enable = 1'b1;
    @(posedge CLK);
    #1;
    check_drive();
    end_test("reset values");

    repeat (40) issue_move(rand_below(21), rand_below(13), rand_below(2));
    wait_drain();
    end_test("random moves");

    repeat (8) begin
      issue_move(rand_below(21), rand_below(13), rand_below(2));
      wait_drain();
      check_drive();
    end
    enable = 1'b0;   // Index keeps counting with the bridge off
    issue_move(rand_below(21), rand_below(13), rand_below(2));
    wait_drain();
    check_drive();
    enable = 1'b1;
    @(posedge CLK);
    #1;
    check_drive();
    end_test("drive table");

    repeat (30) enc_move(rand_below(2) ? 1 : -1);
    issue_move(0, rand_below(13), rand_below(2));
    wait_drain();
    end_test("encoder count");

    status_ready = 1'b0;
    accepted     = 0;
    full_seen    = 1'b0;
    fork
      repeat (20) issue_move(rand_below(4), rand_below(5), rand_below(2));
      begin
        wait (full_seen);
        repeat (300) @(posedge CLK);
        #1;
        if (accepted != capacity) report_mismatch("accepted moves", capacity, accepted);
        if (move_ready !== 1'b0) report_mismatch("move_ready", 0, move_ready);
        while (accepted < 20) begin
          status_ready = rand_below(2);
          @(posedge CLK);
          #1;
        end
        status_ready = 1'b1;
      end
    join
    wait_drain();
    end_test("back-pressure");

    enc_move(2);
    issue_move(0, 0, 1'b1);
    wait_drain();
    enc_move(1);   // Counting goes on while the fault stays
    issue_move(rand_below(21), rand_below(13), rand_below(2));
    issue_move(0, 0, 1'b0);
    wait_drain();
    end_test("encoder fault");

    $display("Passed %0d of %0d tests, failed %0d", tests_passed,
             tests_passed + tests_failed, tests_failed);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: build.f
source/bridge_pkg.sv
source/motion_pkg.sv
source/stream_fifo.sv
source/step_timer.sv
source/phase_sequencer.sv
source/quad_decoder.sv
source/motion_top.sv
tests/tb_motion_top.sv

// File: Makefile
TOP := tb_motion_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module motion_top -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || echo "test failed" >> sim.log
	@cat sim.log
	@if grep -q "test failed" sim.log; then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
